// ==== tb.f ====
+incdir+design
design/peri_pkg.sv
design/peri_if.sv
design/peri_bus.sv
design/csr_timer.sv
design/gpio_ctrl.sv
design/irq_ctrl.sv
design/peri_top.sv
verification/peri_assertions.sv
verification/tb_peri_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   := tb.f
TOP        := tb_peri_top
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert
RUN_ARGS   := +verilator+error+limit+1000
OBJ_DIR    := obj_dir
PASS_MSG   := TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/tb_peri_top.sv ====
/*
 * Testbench for the peripheral subsystem. Drives both PE ports through
 * GPIO register writes, unmapped reads, a time load, the timer and the GPIO
 * interrupts. Checks read data against a register model.
 */
`timescale 1ns/100ps
`include "peri_defs.svh"

module tb_peri_top import peri_pkg::*; ();

  localparam int NP         = `NUM_PE;
  localparam int DW         = `DATA_W;
  localparam int IW         = `IRQ_ID_W;
  localparam int WAIT_LIMIT = 40;

  logic               clk;
  logic               arst_n;
  logic [NP-1:0]      rden;
  logic [NP-1:0]      wren;
  logic [NP*DW-1:0]   addr;
  logic [NP*DW-1:0]   wdata;
  logic [NP*DW/8-1:0] wstrb;
  logic [NP*DW-1:0]   rdata;
  logic [NP-1:0]      ready;
  logic [NP*DW-1:0]   irq;
  logic [NP-1:0]      ack;
  logic [NP*IW-1:0]   irq_id;
  logic               upd_valid;
  sys_time_t          upd_time;
  gpio_t              gpio_in;
  sys_time_t          sys_time;
  logic               second_pulse;
  gpio_t              gpio_out;
  gpio_t              gpio_en;

  integer seed;
  int     mismatches;
  int     timeouts;
  int     ready_cnt  [NP];
  data_t  last_rdata [NP];
  // register model of the shared GPIO block
  gpio_t  dir_m;
  gpio_t  out_m;

  peri_top u_dut (
    .i_pe_clk             (clk),
    .i_arst_n             (arst_n),
    .i_peri_rden          (rden),
    .i_peri_wren          (wren),
    .i_peri_addr          (addr),
    .i_peri_wdata         (wdata),
    .i_peri_wstrb         (wstrb),
    .o_peri_rdata         (rdata),
    .o_peri_ready         (ready),
    .o_irq                (irq),
    .i_irq_ack            (ack),
    .i_irq_id             (irq_id),
    .i_update_valid       (upd_valid),
    .i_update_system_time (upd_time),
    .i_gpio               (gpio_in),
    .o_system_time        (sys_time),
    .o_second_pulse       (second_pulse),
    .o_gpio               (gpio_out),
    .o_gpio_en            (gpio_en)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // responses are counted away from the driving edge
  always @(negedge clk) begin
    for (int p = 0; p < NP; p++) begin
      if (ready[p]) begin
        ready_cnt[p]++;
        last_rdata[p] = rdata[p*DW +: DW];
      end
    end
  end

  function automatic addr_t reg_addr(int sel, reg_ofs_t ofs);
    return (addr_t'(sel) << `PERI_SEL_LSB) | (addr_t'(ofs) << 2);
  endfunction

  function automatic data_t merge_bytes(data_t old_v, data_t new_v, strb_t s);
    data_t m;
    for (int b = 0; b < DW/8; b++) begin
      m[b*8 +: 8] = s[b] ? new_v[b*8 +: 8] : old_v[b*8 +: 8];
    end
    return m;
  endfunction

  // drives on a rising edge and leaves the strobe up until cleared
  task drive_strobe(int pe, logic wr, addr_t a, data_t d, strb_t s);
    rden[pe]               <= !wr;
    wren[pe]               <= wr;
    addr[pe*DW +: DW]      <= a;
    wdata[pe*DW +: DW]     <= d;
    wstrb[pe*DW/8 +: DW/8] <= s;
  endtask

  task wait_ready(int pe, int target);
    int n;
    n = 0;
    while (ready_cnt[pe] < target && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (ready_cnt[pe] < target) begin
      $display("timeout: PE %0d got no ready from its peripheral bus", pe);
      timeouts++;
    end
  endtask

  task access(int pe, logic wr, addr_t a, data_t d, strb_t s);
    int target;
    target = ready_cnt[pe] + 1;
    @(posedge clk);
    drive_strobe(pe, wr, a, d, s);
    @(posedge clk);
    rden[pe] <= 1'b0;
    wren[pe] <= 1'b0;
    wait_ready(pe, target);
  endtask

  task check_read(int pe, addr_t a, data_t exp, string what);
    access(pe, 1'b0, a, '0, '0);
    if (last_rdata[pe] !== exp) begin
      $display("MISMATCH o_peri_rdata[%0d] %s: got %h expected %h",
               pe, what, last_rdata[pe], exp);
      mismatches++;
    end
  endtask

  task acknowledge(int mask, irq_id_t id);
    logic [NP-1:0]    ack_v;
    logic [NP*IW-1:0] id_v;
    for (int p = 0; p < NP; p++) begin
      ack_v[p]         = mask[p];
      id_v[p*IW +: IW] = id;
    end
    @(posedge clk);
    ack    <= ack_v;
    irq_id <= id_v;
    @(posedge clk);
    ack    <= '0;
  endtask

  task wait_irq(int pe, int bit_idx, logic level, string what);
    int n;
    n = 0;
    while (irq[pe*DW + bit_idx] !== level && n < WAIT_LIMIT * 8) begin
      @(negedge clk);
      n++;
    end
    if (irq[pe*DW + bit_idx] !== level) begin
      $display("timeout: %s on PE %0d", what, pe);
      timeouts++;
    end
  endtask

  initial begin
    data_t d [4];
    strb_t s [4];
    int    t0;
    int    t1;
    int    n;
    int    asrt_fails;
    data_t sec_r;
    data_t ns_r;

    seed       = 32'hb133;
    mismatches = 0;
    timeouts   = 0;
    arst_n     = 1'b0;
    rden       = '0;
    wren       = '0;
    addr       = '0;
    wdata      = '0;
    wstrb      = '0;
    ack        = '0;
    irq_id     = '0;
    upd_valid  = 1'b0;
    upd_time   = '0;
    gpio_in    = '0;
    dir_m      = '0;
    out_m      = '0;
    for (int p = 0; p < NP; p++) begin
      ready_cnt[p]  = 0;
      last_rdata[p] = '0;
    end
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    repeat (5) @(posedge clk);

    // both PEs write GPIO registers back to back
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < 4; i++) begin
        d[i] = $random(seed);
        s[i] = strb_t'($random(seed));
      end
      t0 = ready_cnt[0] + 3;
      t1 = ready_cnt[1] + 3;
      @(posedge clk);
      drive_strobe(0, 1'b1, reg_addr(`SEL_GPIO, `GPIO_DIR), d[0], s[0]);
      drive_strobe(1, 1'b1, reg_addr(`SEL_GPIO, `GPIO_OUT), d[1], s[1]);
      @(posedge clk);
      drive_strobe(0, 1'b1, reg_addr(`SEL_GPIO, `GPIO_OUT), d[2], s[2]);
      drive_strobe(1, 1'b1, reg_addr(`SEL_GPIO, `GPIO_DIR), d[3], s[3]);
      @(posedge clk);
      // both PEs hit the same register and PE 0 wins
      drive_strobe(0, 1'b1, reg_addr(`SEL_GPIO, `GPIO_DIR), d[1], s[2]);
      drive_strobe(1, 1'b1, reg_addr(`SEL_GPIO, `GPIO_DIR), d[3], s[0]);
      @(posedge clk);
      rden <= '0;
      wren <= '0;
      wait_ready(0, t0);
      wait_ready(1, t1);
      dir_m = gpio_t'(merge_bytes(data_t'(dir_m), d[0], s[0]));
      out_m = gpio_t'(merge_bytes(data_t'(out_m), d[1], s[1]));
      out_m = gpio_t'(merge_bytes(data_t'(out_m), d[2], s[2]));
      dir_m = gpio_t'(merge_bytes(data_t'(dir_m), d[3], s[3]));
      dir_m = gpio_t'(merge_bytes(data_t'(dir_m), d[1], s[2]));
      check_read(r % NP, reg_addr(`SEL_GPIO, `GPIO_DIR), data_t'(dir_m), "gpio dir");
      check_read((r + 1) % NP, reg_addr(`SEL_GPIO, `GPIO_OUT), data_t'(out_m), "gpio out");
      if (gpio_en !== dir_m) begin
        $display("MISMATCH o_gpio_en: got %h expected %h", gpio_en, dir_m);
        mismatches++;
      end
      if (gpio_out !== out_m) begin
        $display("MISMATCH o_gpio: got %h expected %h", gpio_out, out_m);
        mismatches++;
      end
    end

    // unmapped select values
    check_read(0, reg_addr(5, `CSR_TIME_NS), '0, "unmapped select 5");
    access(1, 1'b1, reg_addr(2, `CSR_TIMER_CMP), $random(seed), 4'hf);
    // an unmapped write must not reach the mapped compare register
    check_read(1, reg_addr(`SEL_CSR, `CSR_TIMER_CMP), '0, "timer cmp after unmapped write");
    check_read(1, reg_addr(32'hfffff, `GPIO_DIR), '0, "unmapped select fffff");

    // load 40 ns before a full second
    sec_r = $random(seed);
    @(posedge clk);
    upd_valid <= 1'b1;
    upd_time  <= {sec_r, `NS_PER_SEC - 32'd40};
    @(posedge clk);
    upd_valid <= 1'b0;
    // loaded value shows one cycle after the load strobe
    @(negedge clk);
    if (sys_time !== {sec_r, `NS_PER_SEC - 32'd40}) begin
      $display("MISMATCH o_system_time: got %h expected %h",
               sys_time, {sec_r, `NS_PER_SEC - 32'd40});
      mismatches++;
    end
    n = 0;
    while (!second_pulse && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!second_pulse) begin
      $display("timeout: no second pulse after the time load");
      timeouts++;
    end
    access(0, 1'b0, reg_addr(`SEL_CSR, `CSR_TIME_NS), '0, '0);
    if (last_rdata[0] >= 32'd40) begin
      $display("MISMATCH o_peri_rdata[0] time ns: got %h expected below %h",
               last_rdata[0], 32'd40);
      mismatches++;
    end
    check_read(0, reg_addr(`SEL_CSR, `CSR_TIME_SEC), sec_r + 32'd1, "time sec");

    // timer compare on PE 1 only
    access(1, 1'b0, reg_addr(`SEL_CSR, `CSR_TIME_NS), '0, '0);
    ns_r = last_rdata[1];
    access(1, 1'b1, reg_addr(`SEL_CSR, `CSR_TIMER_CMP), ns_r + 32'd200, 4'hf);
    access(1, 1'b1, reg_addr(`SEL_CSR, `CSR_TIMER_EN), 32'd1, 4'h1);
    check_read(1, reg_addr(`SEL_CSR, `CSR_TIMER_CMP), ns_r + 32'd200, "timer cmp");
    wait_irq(1, `IRQ_TIMER, 1'b1, "timer interrupt did not rise");
    if (irq[`IRQ_TIMER] !== 1'b0) begin
      $display("MISMATCH o_irq[0] timer bit: got %h expected %h", irq[`IRQ_TIMER], 1'b0);
      mismatches++;
    end
    access(1, 1'b1, reg_addr(`SEL_CSR, `CSR_TIMER_EN), 32'd0, 4'h1);
    acknowledge(2, irq_id_t'(`IRQ_TIMER));
    wait_irq(1, `IRQ_TIMER, 1'b0, "timer pending bit did not clear");

    // rising edge on pin 5 reaches every PE
    access(0, 1'b1, reg_addr(`SEL_GPIO, `GPIO_INT_MASK), 32'h0000_0020, 4'h3);
    @(posedge clk);
    gpio_in <= 16'h0020;
    for (int p = 0; p < NP; p++) begin
      wait_irq(p, `IRQ_GPIO, 1'b1, "gpio interrupt did not rise");
    end
    check_read(1, reg_addr(`SEL_GPIO, `GPIO_INT_STAT), 32'h0000_0020, "gpio status");
    check_read(0, reg_addr(`SEL_GPIO, `GPIO_IN), 32'h0000_0020, "gpio input");
    access(0, 1'b1, reg_addr(`SEL_GPIO, `GPIO_INT_STAT), 32'h0000_0020, 4'h1);
    acknowledge((1 << NP) - 1, irq_id_t'(`IRQ_GPIO));
    for (int p = 0; p < NP; p++) begin
      wait_irq(p, `IRQ_GPIO, 1'b0, "gpio pending bit did not clear");
    end

    repeat (4) @(posedge clk);
    asrt_fails = u_dut.u_peri_assertions.fail_count;
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, asrt_fails);
    if (mismatches == 0 && timeouts == 0 && asrt_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== verification/peri_assertions.sv ====
/*
 * Concurrent checks on the peripheral top ports: response latency, reset
 * state, system time step and second pulse. Bound into peri_top.
 */
`timescale 1ns/100ps
`include "peri_defs.svh"

module peri_assertions import peri_pkg::*; (
  input logic                       i_pe_clk,
  input logic                       i_arst_n,
  input logic [`NUM_PE-1:0]         i_peri_rden,
  input logic [`NUM_PE-1:0]         i_peri_wren,
  input logic [`NUM_PE-1:0]         o_peri_ready,
  input logic [`NUM_PE*`DATA_W-1:0] o_irq,
  input logic                       i_update_valid,
  input sys_time_t                  o_system_time,
  input logic                       o_second_pulse,
  input gpio_t                      o_gpio,
  input gpio_t                      o_gpio_en
);

  int    fail_count = 0;
  data_t ns;
  data_t sec;

  assign ns  = o_system_time[`DATA_W-1:0];
  assign sec = o_system_time[2*`DATA_W-1:`DATA_W];

  // ready exactly two cycles after each strobe, and never otherwise
  a_ready_latency: assert property (@(posedge i_pe_clk) disable iff (!i_arst_n)
    o_peri_ready == $past(i_peri_rden | i_peri_wren, 2))
    else begin
      $error("ready does not follow its strobe by two cycles");
      fail_count++;
    end

  a_reset_state: assert property (@(posedge i_pe_clk)
    !i_arst_n |-> (o_peri_ready == '0 && o_irq == '0 && !o_second_pulse &&
                   o_gpio == '0 && o_gpio_en == '0 && o_system_time == '0))
    else begin
      $error("outputs are not idle during reset");
      fail_count++;
    end

  a_time_step: assert property (@(posedge i_pe_clk) disable iff (!i_arst_n)
    ($past(i_arst_n) && !$past(i_update_valid) &&
     $past(ns) < `NS_PER_SEC - `TIME_STEP_NS) |-> ns == $past(ns) + `TIME_STEP_NS)
    else begin
      $error("nanoseconds did not advance by one step");
      fail_count++;
    end

  a_pulse_on_second: assert property (@(posedge i_pe_clk) disable iff (!i_arst_n)
    o_second_pulse |-> sec == $past(sec) + 32'd1)
    else begin
      $error("second pulse without a seconds increment");
      fail_count++;
    end

  a_second_has_pulse: assert property (@(posedge i_pe_clk) disable iff (!i_arst_n)
    ($past(i_arst_n) && !$past(i_update_valid) && sec != $past(sec)) |-> o_second_pulse)
    else begin
      $error("seconds changed without a second pulse");
      fail_count++;
    end

endmodule

bind peri_top peri_assertions u_peri_assertions (
  .i_pe_clk       (i_pe_clk),
  .i_arst_n       (i_arst_n),
  .i_peri_rden    (i_peri_rden),
  .i_peri_wren    (i_peri_wren),
  .o_peri_ready   (o_peri_ready),
  .o_irq          (o_irq),
  .i_update_valid (i_update_valid),
  .o_system_time  (o_system_time),
  .o_second_pulse (o_second_pulse),
  .o_gpio         (o_gpio),
  .o_gpio_en      (o_gpio_en)
);

// ==== design/peri_top.sv ====
/*
 * Peripheral subsystem top. One bus and one interrupt controller per PE,
 * a shared CSR/timer block and a shared GPIO block. PE ports are flattened,
 * PE p uses slice p of every vector.
 */
`timescale 1ns/100ps
`include "peri_defs.svh"

module peri_top import peri_pkg::*; (
  input  logic                           i_pe_clk,
  input  logic                           i_arst_n,
  input  logic [`NUM_PE-1:0]             i_peri_rden,
  input  logic [`NUM_PE-1:0]             i_peri_wren,
  input  logic [`NUM_PE*`DATA_W-1:0]     i_peri_addr,
  input  logic [`NUM_PE*`DATA_W-1:0]     i_peri_wdata,
  input  logic [`NUM_PE*`DATA_W/8-1:0]   i_peri_wstrb,
  output logic [`NUM_PE*`DATA_W-1:0]     o_peri_rdata,
  output logic [`NUM_PE-1:0]             o_peri_ready,
  output logic [`NUM_PE*`DATA_W-1:0]     o_irq,
  input  logic [`NUM_PE-1:0]             i_irq_ack,
  input  logic [`NUM_PE*`IRQ_ID_W-1:0]   i_irq_id,
  input  logic                           i_update_valid,
  input  sys_time_t                      i_update_system_time,
  input  gpio_t                          i_gpio,
  output sys_time_t                      o_system_time,
  output logic                           o_second_pulse,
  output gpio_t                          o_gpio,
  output gpio_t                          o_gpio_en
);

  logic time_int [`NUM_PE];
  logic gpio_int;

  peri_if csr_link  [`NUM_PE] ();
  peri_if gpio_link [`NUM_PE] ();

  for (genvar p = 0; p < `NUM_PE; p++) begin : g_pe
    peri_bus u_peri_bus (
      .i_pe_clk   (i_pe_clk),
      .i_arst_n   (i_arst_n),
      .i_rden     (i_peri_rden[p]),
      .i_wren     (i_peri_wren[p]),
      .i_addr     (i_peri_addr[p*`DATA_W +: `DATA_W]),
      .i_wdata    (i_peri_wdata[p*`DATA_W +: `DATA_W]),
      .i_wstrb    (i_peri_wstrb[p*`DATA_W/8 +: `DATA_W/8]),
      .o_rdata    (o_peri_rdata[p*`DATA_W +: `DATA_W]),
      .o_ready    (o_peri_ready[p]),
      .csr_port   (csr_link[p]),
      .gpio_port  (gpio_link[p])
    );

    // gpio interrupt goes to every PE
    irq_ctrl u_irq_ctrl (
      .i_pe_clk   (i_pe_clk),
      .i_arst_n   (i_arst_n),
      .i_time_int (time_int[p]),
      .i_gpio_int (gpio_int),
      .i_irq_ack  (i_irq_ack[p]),
      .i_irq_id   (i_irq_id[p*`IRQ_ID_W +: `IRQ_ID_W]),
      .o_irq      (o_irq[p*`DATA_W +: `DATA_W])
    );
  end

  csr_timer u_csr_timer (
    .i_pe_clk             (i_pe_clk),
    .i_arst_n             (i_arst_n),
    .i_update_valid       (i_update_valid),
    .i_update_system_time (i_update_system_time),
    .o_system_time        (o_system_time),
    .o_second_pulse       (o_second_pulse),
    .o_time_int           (time_int),
    .links                (csr_link)
  );

  gpio_ctrl u_gpio_ctrl (
    .i_pe_clk   (i_pe_clk),
    .i_arst_n   (i_arst_n),
    .i_gpio     (i_gpio),
    .o_gpio     (o_gpio),
    .o_gpio_en  (o_gpio_en),
    .o_gpio_int (gpio_int),
    .links      (gpio_link)
  );

endmodule

// ==== design/irq_ctrl.sv ====
/*
 * Per-PE interrupt controller. Latches the timer and GPIO interrupt levels
 * into a 32-bit pending vector; the PE clears one bit by acknowledge and id.
 */
`timescale 1ns/100ps
`include "peri_defs.svh"

module irq_ctrl import peri_pkg::*; (
  input  logic     i_pe_clk,
  input  logic     i_arst_n,
  input  logic     i_time_int,
  input  logic     i_gpio_int,
  input  logic     i_irq_ack,
  input  irq_id_t  i_irq_id,
  output irq_vec_t o_irq
);

  irq_vec_t pend_q;
  irq_vec_t pend_d;

  always_comb begin
    pend_d = pend_q;
    if (i_irq_ack) begin
      pend_d[i_irq_id] = 1'b0;
    end
    // a source still high sets its bit again
    if (i_time_int) begin
      pend_d[`IRQ_TIMER] = 1'b1;
    end
    if (i_gpio_int) begin
      pend_d[`IRQ_GPIO] = 1'b1;
    end
  end

  always_ff @(posedge i_pe_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pend_q <= '0;
    end else begin
      pend_q <= pend_d;
    end
  end

  assign o_irq = pend_q;

endmodule

// ==== design/gpio_ctrl.sv ====
/*
 * 16-pin GPIO shared by all PEs. Holds direction (1 is output), output data
 * and interrupt mask, samples the pins through two flops and latches masked
 * rising edges into a write-1-to-clear status. PE 0 wins write conflicts.
 */
`timescale 1ns/100ps
`include "peri_defs.svh"

module gpio_ctrl import peri_pkg::*; (
  input  logic  i_pe_clk,
  input  logic  i_arst_n,
  input  gpio_t i_gpio,
  output gpio_t o_gpio,
  output gpio_t o_gpio_en,
  output logic  o_gpio_int,
  peri_if.peri  links [`NUM_PE]
);

  logic     wren_v  [`NUM_PE];
  reg_ofs_t ofs_v   [`NUM_PE];
  data_t    wdata_v [`NUM_PE];
  strb_t    wstrb_v [`NUM_PE];
  gpio_t    dir_q;
  gpio_t    out_q;
  gpio_t    mask_q;
  gpio_t    stat_q;
  gpio_t    dir_d;
  gpio_t    out_d;
  gpio_t    mask_d;
  gpio_t    stat_clr;
  gpio_t    sync1_q;
  gpio_t    sync2_q;
  gpio_t    prev_q;
  gpio_t    rise;

  // walk PEs downwards so PE 0 is applied last
  always_comb begin
    dir_d    = dir_q;
    out_d    = out_q;
    mask_d   = mask_q;
    stat_clr = '0;
    for (int p = `NUM_PE-1; p >= 0; p--) begin
      if (wren_v[p]) begin
        case (ofs_v[p])
          `GPIO_DIR:      dir_d    = gpio_t'(strb_merge(data_t'(dir_q), wdata_v[p], wstrb_v[p]));
          `GPIO_OUT:      out_d    = gpio_t'(strb_merge(data_t'(out_q), wdata_v[p], wstrb_v[p]));
          `GPIO_INT_MASK: mask_d   = gpio_t'(strb_merge(data_t'(mask_q), wdata_v[p], wstrb_v[p]));
          `GPIO_INT_STAT: stat_clr = gpio_t'(strb_merge('0, wdata_v[p], wstrb_v[p]));
          default:        ;
        endcase
      end
    end
  end

  assign rise = sync2_q & ~prev_q & mask_q;

  always_ff @(posedge i_pe_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      dir_q   <= '0;
      out_q   <= '0;
      mask_q  <= '0;
      stat_q  <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      dir_q   <= dir_d;
      out_q   <= out_d;
      mask_q  <= mask_d;
      // a new edge wins over a clear in the same cycle
      stat_q  <= (stat_q & ~stat_clr) | rise;
      sync1_q <= i_gpio;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign o_gpio     = out_q;
  assign o_gpio_en  = dir_q;
  assign o_gpio_int = |stat_q;

  for (genvar p = 0; p < `NUM_PE; p++) begin : g_pe
    data_t rd_val;
    data_t rdata_q;
    logic  ready_q;

    assign wren_v[p]  = links[p].wren;
    assign ofs_v[p]   = links[p].ofs;
    assign wdata_v[p] = links[p].wdata;
    assign wstrb_v[p] = links[p].wstrb;

    always_comb begin
      case (links[p].ofs)
        `GPIO_DIR:      rd_val = data_t'(dir_q);
        `GPIO_OUT:      rd_val = data_t'(out_q);
        `GPIO_IN:       rd_val = data_t'(sync2_q);
        `GPIO_INT_MASK: rd_val = data_t'(mask_q);
        `GPIO_INT_STAT: rd_val = data_t'(stat_q);
        default:        rd_val = '0;
      endcase
    end

    always_ff @(posedge i_pe_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        ready_q <= 1'b0;
      end else begin
        ready_q <= links[p].rden | links[p].wren;
      end
    end

    always_ff @(posedge i_pe_clk) begin
      rdata_q <= links[p].rden ? rd_val : '0;
    end

    assign links[p].rdata = rdata_q;
    assign links[p].ready = ready_q;
  end

endmodule

// ==== design/csr_timer.sv ====
/*
 * Control/status block. Keeps the system time, advancing TIME_STEP_NS per
 * clock with a one-cycle pulse per second, and holds a compare and enable
 * register per PE. The timer interrupt of a PE is high while enabled and
 * while the nanosecond field equals its compare.
 */
`timescale 1ns/100ps
`include "peri_defs.svh"

module csr_timer import peri_pkg::*; (
  input  logic      i_pe_clk,
  input  logic      i_arst_n,
  input  logic      i_update_valid,
  input  sys_time_t i_update_system_time,
  output sys_time_t o_system_time,
  output logic      o_second_pulse,
  output logic      o_time_int [`NUM_PE],
  peri_if.peri      links [`NUM_PE]
);

  data_t sec_q;
  data_t ns_q;
  logic  second_pulse_q;

  // time counter, a load overrides the step
  always_ff @(posedge i_pe_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sec_q          <= '0;
      ns_q           <= '0;
      second_pulse_q <= 1'b0;
    end else if (i_update_valid) begin
      {sec_q, ns_q}  <= i_update_system_time;
      second_pulse_q <= 1'b0;
    end else if (ns_q >= `NS_PER_SEC - `TIME_STEP_NS) begin
      ns_q           <= ns_q + `TIME_STEP_NS - `NS_PER_SEC;
      sec_q          <= sec_q + 1'b1;
      second_pulse_q <= 1'b1;
    end else begin
      ns_q           <= ns_q + `TIME_STEP_NS;
      second_pulse_q <= 1'b0;
    end
  end

  assign o_system_time  = {sec_q, ns_q};
  assign o_second_pulse = second_pulse_q;

  for (genvar p = 0; p < `NUM_PE; p++) begin : g_pe
    data_t cmp_q;
    logic  en_q;
    data_t rd_val;
    data_t rdata_q;
    logic  ready_q;

    // compare and enable of this PE only
    always_ff @(posedge i_pe_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        cmp_q <= '0;
        en_q  <= 1'b0;
      end else if (links[p].wren) begin
        if (links[p].ofs == `CSR_TIMER_CMP) begin
          cmp_q <= strb_merge(cmp_q, links[p].wdata, links[p].wstrb);
        end
        if (links[p].ofs == `CSR_TIMER_EN && links[p].wstrb[0]) begin
          en_q <= links[p].wdata[0];
        end
      end
    end

    always_comb begin
      case (links[p].ofs)
        `CSR_TIME_NS:   rd_val = ns_q;
        `CSR_TIME_SEC:  rd_val = sec_q;
        `CSR_TIMER_CMP: rd_val = cmp_q;
        `CSR_TIMER_EN:  rd_val = data_t'(en_q);
        default:        rd_val = '0;
      endcase
    end

    always_ff @(posedge i_pe_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        ready_q <= 1'b0;
      end else begin
        ready_q <= links[p].rden | links[p].wren;
      end
    end

    always_ff @(posedge i_pe_clk) begin
      rdata_q <= links[p].rden ? rd_val : '0;
    end

    assign links[p].rdata = rdata_q;
    assign links[p].ready = ready_q;
    assign o_time_int[p]  = en_q && (ns_q == cmp_q);
  end

endmodule

// ==== design/peri_bus.sv ====
/*
 * Per-PE peripheral bus. Decodes the select field of the address, registers
 * the access onto the CSR or GPIO link and returns the link response, so the
 * PE sees ready two cycles after its strobe. Unmapped accesses read zero.
 */
`timescale 1ns/100ps
`include "peri_defs.svh"

module peri_bus import peri_pkg::*; (
  input  logic        i_pe_clk,
  input  logic        i_arst_n,
  input  logic        i_rden,
  input  logic        i_wren,
  input  addr_t       i_addr,
  input  data_t       i_wdata,
  input  strb_t       i_wstrb,
  output data_t       o_rdata,
  output logic        o_ready,
  peri_if.bus         csr_port,
  peri_if.bus         gpio_port
);

  logic [$bits(addr_t)-`PERI_SEL_LSB-1:0] sel_field;
  peri_sel_e sel;
  logic      access;
  logic      csr_rd_q;
  logic      csr_wr_q;
  logic      gpio_rd_q;
  logic      gpio_wr_q;
  logic      none_q;
  logic      none_dly_q;
  reg_ofs_t  ofs_q;
  data_t     wdata_q;
  strb_t     wstrb_q;

  assign sel_field = i_addr[$bits(addr_t)-1:`PERI_SEL_LSB];
  assign access    = i_rden | i_wren;

  always_comb begin
    if (sel_field == `SEL_CSR) begin
      sel = PERI_CSR;
    end else if (sel_field == `SEL_GPIO) begin
      sel = PERI_GPIO;
    end else begin
      sel = PERI_NONE;
    end
  end

  always_ff @(posedge i_pe_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      csr_rd_q   <= 1'b0;
      csr_wr_q   <= 1'b0;
      gpio_rd_q  <= 1'b0;
      gpio_wr_q  <= 1'b0;
      none_q     <= 1'b0;
      none_dly_q <= 1'b0;
    end else begin
      csr_rd_q   <= i_rden && (sel == PERI_CSR);
      csr_wr_q   <= i_wren && (sel == PERI_CSR);
      gpio_rd_q  <= i_rden && (sel == PERI_GPIO);
      gpio_wr_q  <= i_wren && (sel == PERI_GPIO);
      // unmapped reply waits one more cycle to match the peripherals
      none_q     <= access && (sel == PERI_NONE);
      none_dly_q <= none_q;
    end
  end

  // word offset and write payload, shared by both links
  always_ff @(posedge i_pe_clk) begin
    if (access) begin
      ofs_q   <= i_addr[`REG_OFS_W+1:2];
      wdata_q <= i_wdata;
      wstrb_q <= i_wstrb;
    end
  end

  assign csr_port.rden   = csr_rd_q;
  assign csr_port.wren   = csr_wr_q;
  assign csr_port.ofs    = ofs_q;
  assign csr_port.wdata  = wdata_q;
  assign csr_port.wstrb  = wstrb_q;

  assign gpio_port.rden  = gpio_rd_q;
  assign gpio_port.wren  = gpio_wr_q;
  assign gpio_port.ofs   = ofs_q;
  assign gpio_port.wdata = wdata_q;
  assign gpio_port.wstrb = wstrb_q;

  // at most one response per cycle, pick the one that is ready
  assign o_ready = csr_port.ready | gpio_port.ready | none_dly_q;
  assign o_rdata = csr_port.ready  ? csr_port.rdata  :
                   gpio_port.ready ? gpio_port.rdata : '0;

endmodule

// ==== design/peri_if.sv ====
/*
 * One PE's access path to one peripheral. The bus side drives single-cycle
 * strobes, the peripheral answers one cycle later with ready and rdata.
 */
`timescale 1ns/100ps

interface peri_if import peri_pkg::*; ();

  logic     wren;
  logic     rden;
  reg_ofs_t ofs;
  data_t    wdata;
  strb_t    wstrb;
  // rdata is zero on write responses
  data_t    rdata;
  logic     ready;

  modport bus (
    output wren, rden, ofs, wdata, wstrb,
    input  rdata, ready
  );

  modport peri (
    input  wren, rden, ofs, wdata, wstrb,
    output rdata, ready
  );

endinterface

// ==== design/peri_pkg.sv ====
/*
 * Shared types of the peripheral subsystem, plus the byte-strobe merge
 * used by every writable register. Imported by the RTL and the testbench.
 */
`include "peri_defs.svh"

package peri_pkg;

  typedef logic [`DATA_W-1:0]      data_t;
  typedef logic [`DATA_W-1:0]      addr_t;
  typedef logic [`DATA_W/8-1:0]    strb_t;
  typedef logic [`REG_OFS_W-1:0]   reg_ofs_t;
  typedef logic [`GPIO_W-1:0]      gpio_t;
  // seconds in the upper word, nanoseconds in the lower word
  typedef logic [2*`DATA_W-1:0]    sys_time_t;
  typedef logic [`DATA_W-1:0]      irq_vec_t;
  typedef logic [`IRQ_ID_W-1:0]    irq_id_t;

  typedef enum logic [1:0] {
    PERI_CSR,
    PERI_GPIO,
    PERI_NONE
  } peri_sel_e;

  // replace the bytes of old_val enabled in strb
  function automatic data_t strb_merge(data_t old_val, data_t new_val, strb_t strb);
    data_t merged;
    merged = old_val;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        merged[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return merged;
  endfunction

endpackage

// ==== design/peri_defs.svh ====
/*
 * Constants for the peripheral subsystem: PE count, widths, address map
 * and system time rules. Included by the package and by the RTL modules.
 */
`ifndef PERI_DEFS_SVH
`define PERI_DEFS_SVH

`define NUM_PE         2
`define DATA_W         32
`define GPIO_W         16
`define IRQ_ID_W       5
`define REG_OFS_W      4

// address map, select field starts at bit 12
`define PERI_SEL_LSB   12
`define SEL_CSR        0
`define SEL_GPIO       1

// csr word offsets
`define CSR_TIME_NS    4'd0
`define CSR_TIME_SEC   4'd1
`define CSR_TIMER_CMP  4'd2
`define CSR_TIMER_EN   4'd3

// gpio word offsets
`define GPIO_DIR       4'd0
`define GPIO_OUT       4'd1
`define GPIO_IN        4'd2
`define GPIO_INT_MASK  4'd3
`define GPIO_INT_STAT  4'd4

// system time rules
`define TIME_STEP_NS   32'd4
`define NS_PER_SEC     32'd1000000000

// pending bit indexes
`define IRQ_TIMER      0
`define IRQ_GPIO       1

`endif
